/* common/hq_defs.svh */
`ifndef HQ_DEFS_SVH
`define HQ_DEFS_SVH

`define HQ_SAMPLE_W   32
`define HQ_FRAC_BITS  22
`define HQ_NUM_ROWS   4
`define HQ_NUM_CHUNKS 8
`define HQ_NUM_CW     16
// Stages inside each complex multiplier lane
`define HQ_MULT_LAT   2

`endif

/* common/hq_pkg.sv */
`include "hq_defs.svh"

package hq_pkg;

    // Signed fixed point, HQ_FRAC_BITS fractional bits
    typedef logic signed [`HQ_SAMPLE_W-1:0] sample_t;

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_t;

    typedef logic [$clog2(`HQ_NUM_CHUNKS)-1:0] chunk_idx_t;
    typedef logic [$clog2(`HQ_NUM_CW)-1:0]     cw_idx_t;

    typedef cplx_t  [`HQ_NUM_CHUNKS-1:0] h_row_t;
    typedef h_row_t [`HQ_NUM_ROWS-1:0]   h_mat_t;

    // One operand or product per row of H
    typedef cplx_t [`HQ_NUM_ROWS-1:0] lane_vec_t;

    typedef struct packed {
        logic valid;
        logic last_chunk;
        logic last_cw;
    } item_tag_t;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_e;

endpackage

/* hw/hq_sequencer.sv */
`timescale 1ns/1ns
`include "hq_defs.svh"

module hq_sequencer (
    input  logic               clk,
    input  logic               rst,
    input  logic               start_i,
    output hq_pkg::cw_idx_t    cw_o,
    output hq_pkg::chunk_idx_t chunk_o,
    output hq_pkg::item_tag_t  tag_o
);
    import hq_pkg::*;

    seq_state_e state;
    cw_idx_t    cw_cnt;
    chunk_idx_t chunk_cnt;
    logic       last_chunk;
    logic       last_cw;

    assign last_chunk = (chunk_cnt == chunk_idx_t'(`HQ_NUM_CHUNKS - 1));
    assign last_cw    = (cw_cnt == cw_idx_t'(`HQ_NUM_CW - 1));

    // Counters wrap back to zero after the final item
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= SEQ_IDLE;
            cw_cnt    <= '0;
            chunk_cnt <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (start_i) begin
                        state     <= SEQ_RUN;
                        cw_cnt    <= '0;
                        chunk_cnt <= '0;
                    end
                end
                SEQ_RUN: begin
                    chunk_cnt <= chunk_cnt + 1'b1;
                    if (last_chunk) begin
                        cw_cnt <= cw_cnt + 1'b1;
                        if (last_cw)
                            state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    assign cw_o    = cw_cnt;
    assign chunk_o = chunk_cnt;

    always_comb begin
        tag_o.valid      = (state == SEQ_RUN);
        tag_o.last_chunk = last_chunk;
        tag_o.last_cw    = last_cw;
    end

endmodule

/* hw/codebook_fetch.sv */
`timescale 1ns/1ns
`include "hq_defs.svh"

module codebook_fetch (
    input  logic               clk,
    input  logic               rst,
    input  hq_pkg::h_mat_t     h_mat_i,
    input  hq_pkg::cw_idx_t    cw_i,
    input  hq_pkg::chunk_idx_t chunk_i,
    input  hq_pkg::item_tag_t  tag_i,
    output hq_pkg::lane_vec_t  h_ops_o,
    output hq_pkg::lane_vec_t  s_ops_o,
    output hq_pkg::item_tag_t  tag_o
);
    import hq_pkg::*;

    // Five codebook symbols: +half, -half, +half*i, -half*i, zero
    typedef logic [2:0] cb_sym_t;
    localparam cb_sym_t SP = 3'd0;
    localparam cb_sym_t SN = 3'd1;
    localparam cb_sym_t SJ = 3'd2;
    localparam cb_sym_t SM = 3'd3;
    localparam cb_sym_t SZ = 3'd4;

    localparam sample_t HALF = sample_t'(2 ** (`HQ_FRAC_BITS - 1));

    lane_vec_t h_sel;
    lane_vec_t s_sel;

    function automatic cb_sym_t cb_lookup(cw_idx_t q, logic [1:0] k, logic j);
        logic [11:0] pair;
        cb_sym_t     sym;
        // Row 2 pair then row 3 pair, each as {j=0, j=1}
        case (q)
            4'd0:    pair = {SP, SP, SN, SP};
            4'd1:    pair = {SP, SJ, SJ, SP};
            4'd2:    pair = {SP, SN, SP, SP};
            4'd3:    pair = {SP, SM, SM, SP};
            4'd4:    pair = {SN, SP, SN, SN};
            4'd5:    pair = {SN, SJ, SJ, SN};
            4'd6:    pair = {SN, SN, SP, SN};
            4'd7:    pair = {SN, SM, SM, SN};
            4'd8:    pair = {SJ, SP, SN, SJ};
            4'd9:    pair = {SJ, SJ, SJ, SJ};
            4'd10:   pair = {SJ, SN, SP, SJ};
            4'd11:   pair = {SJ, SM, SM, SJ};
            4'd12:   pair = {SM, SP, SN, SM};
            4'd13:   pair = {SM, SJ, SJ, SM};
            4'd14:   pair = {SM, SN, SP, SM};
            default: pair = {SM, SM, SM, SM};
        endcase
        case (k)
            2'd0:    sym = SP;
            2'd1:    sym = j ? SP : SN;
            2'd2:    sym = j ? pair[8:6] : pair[11:9];
            default: sym = j ? pair[2:0] : pair[5:3];
        endcase
        return sym;
    endfunction

    function automatic cplx_t sym_to_cplx(cb_sym_t s);
        cplx_t v;
        v = '0;
        case (s)
            SP:      v.re = HALF;
            SN:      v.re = -HALF;
            SJ:      v.im = HALF;
            SM:      v.im = -HALF;
            default: v = '0;
        endcase
        return v;
    endfunction

    always_comb begin
        for (int k = 0; k < `HQ_NUM_ROWS; k++) begin
            h_sel[k] = h_mat_i[k][chunk_i];
            s_sel[k] = sym_to_cplx(cb_lookup(cw_i, 2'(k), chunk_i[0]));
        end
    end

    always_ff @(posedge clk) begin
        h_ops_o <= h_sel;
        s_ops_o <= s_sel;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            tag_o <= '0;
        else
            tag_o <= tag_i;
    end

endmodule

/* hw/cmult/cmult_lane.sv */
`timescale 1ns/1ns
`include "hq_defs.svh"

module cmult_lane (
    input  logic          clk,
    input  logic          rst,
    input  hq_pkg::cplx_t a_i,
    input  hq_pkg::cplx_t b_i,
    output hq_pkg::cplx_t p_o
);
    import hq_pkg::*;

    localparam int PW = 2 * `HQ_SAMPLE_W;

    logic signed [PW-1:0] rr_q;
    logic signed [PW-1:0] ii_q;
    logic signed [PW-1:0] ri_q;
    logic signed [PW-1:0] ir_q;
    // One extra bit so the combine cannot overflow before scaling
    logic signed [PW:0]   re_full;
    logic signed [PW:0]   im_full;

    assign re_full = rr_q - ii_q;
    assign im_full = ri_q + ir_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rr_q <= '0;
            ii_q <= '0;
            ri_q <= '0;
            ir_q <= '0;
            p_o  <= '0;
        end else begin
            rr_q <= a_i.re * b_i.re;
            ii_q <= a_i.im * b_i.im;
            ri_q <= a_i.re * b_i.im;
            ir_q <= a_i.im * b_i.re;
            p_o.re <= sample_t'(re_full >>> `HQ_FRAC_BITS);
            p_o.im <= sample_t'(im_full >>> `HQ_FRAC_BITS);
        end
    end

endmodule

/* hw/cmult/hq_mult_stage.sv */
`timescale 1ns/1ns
`include "hq_defs.svh"

module hq_mult_stage (
    input  logic              clk,
    input  logic              rst,
    input  hq_pkg::lane_vec_t h_ops_i,
    input  hq_pkg::lane_vec_t s_ops_i,
    input  hq_pkg::item_tag_t tag_i,
    output hq_pkg::lane_vec_t prod_o,
    output hq_pkg::item_tag_t tag_o
);
    import hq_pkg::*;

    item_tag_t tag_pipe [`HQ_MULT_LAT];

    for (genvar g = 0; g < `HQ_NUM_ROWS; g++) begin : g_lane
        cmult_lane u_lane (
            .clk (clk),
            .rst (rst),
            .a_i (h_ops_i[g]),
            .b_i (s_ops_i[g]),
            .p_o (prod_o[g])
        );
    end

    // Tag follows the products through the lane pipeline
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `HQ_MULT_LAT; i++)
                tag_pipe[i] <= '0;
        end else begin
            tag_pipe[0] <= tag_i;
            for (int i = 1; i < `HQ_MULT_LAT; i++)
                tag_pipe[i] <= tag_pipe[i-1];
        end
    end

    assign tag_o = tag_pipe[`HQ_MULT_LAT-1];

endmodule

/* hw/hq_sum_stage.sv */
`timescale 1ns/1ns
`include "hq_defs.svh"

module hq_sum_stage (
    input  logic              clk,
    input  logic              rst,
    input  hq_pkg::lane_vec_t prod_i,
    input  hq_pkg::item_tag_t tag_i,
    output hq_pkg::cplx_t     hq_o,
    output logic              hq_valid_o,
    output logic              cw_done_o,
    output logic              all_done_o
);
    import hq_pkg::*;

    cplx_t sum;

    // Plain 32-bit adds, overflow wraps
    always_comb begin
        sum = '0;
        for (int k = 0; k < `HQ_NUM_ROWS; k++) begin
            sum.re = sum.re + prod_i[k].re;
            sum.im = sum.im + prod_i[k].im;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hq_o       <= '0;
            hq_valid_o <= 1'b0;
            cw_done_o  <= 1'b0;
            all_done_o <= 1'b0;
        end else begin
            hq_o       <= sum;
            hq_valid_o <= tag_i.valid;
            cw_done_o  <= tag_i.valid & tag_i.last_chunk;
            all_done_o <= tag_i.valid & tag_i.last_chunk & tag_i.last_cw;
        end
    end

endmodule

/* hw/hq_precoder_top.sv */
`timescale 1ns/1ns

module hq_precoder_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           start_i,
    input  hq_pkg::h_mat_t h_mat_i,
    output hq_pkg::cplx_t  hq_o,
    output logic           hq_valid_o,
    output logic           cw_done_o,
    output logic           all_done_o
);
    import hq_pkg::*;

    cw_idx_t    seq_cw;
    chunk_idx_t seq_chunk;
    item_tag_t  seq_tag;
    lane_vec_t  h_ops;
    lane_vec_t  s_ops;
    item_tag_t  fetch_tag;
    lane_vec_t  prod;
    item_tag_t  mult_tag;

    hq_sequencer u_seq (
        .clk     (clk),
        .rst     (rst),
        .start_i (start_i),
        .cw_o    (seq_cw),
        .chunk_o (seq_chunk),
        .tag_o   (seq_tag)
    );

    codebook_fetch u_fetch (
        .clk     (clk),
        .rst     (rst),
        .h_mat_i (h_mat_i),
        .cw_i    (seq_cw),
        .chunk_i (seq_chunk),
        .tag_i   (seq_tag),
        .h_ops_o (h_ops),
        .s_ops_o (s_ops),
        .tag_o   (fetch_tag)
    );

    hq_mult_stage u_mult (
        .clk     (clk),
        .rst     (rst),
        .h_ops_i (h_ops),
        .s_ops_i (s_ops),
        .tag_i   (fetch_tag),
        .prod_o  (prod),
        .tag_o   (mult_tag)
    );

    hq_sum_stage u_sum (
        .clk        (clk),
        .rst        (rst),
        .prod_i     (prod),
        .tag_i      (mult_tag),
        .hq_o       (hq_o),
        .hq_valid_o (hq_valid_o),
        .cw_done_o  (cw_done_o),
        .all_done_o (all_done_o)
    );

endmodule

/* sim/hq_precoder_properties.sv */
`timescale 1ns/1ns

module hq_precoder_properties (
    input logic clk,
    input logic rst,
    input logic valid_i,
    input logic cw_done_i,
    input logic all_done_i
);

    a_cw_done_valid: assert property (@(posedge clk) disable iff (rst) cw_done_i |-> valid_i)
        else $error("cw_done_o high without hq_valid_o");

    a_all_done_cw: assert property (@(posedge clk) disable iff (rst) all_done_i |-> cw_done_i)
        else $error("all_done_o high without cw_done_o");

    // Run ends cleanly after the last output
    a_all_done_end: assert property (@(posedge clk) disable iff (rst) all_done_i |=> !valid_i)
        else $error("hq_valid_o still high after all_done_o");

endmodule

bind hq_precoder_top hq_precoder_properties u_props (
    .clk        (clk),
    .rst        (rst),
    .valid_i    (hq_valid_o),
    .cw_done_i  (cw_done_o),
    .all_done_i (all_done_o)
);

/* sim/hq_precoder_tb.sv */
`timescale 1ns/1ns
`include "hq_defs.svh"

module hq_precoder_tb;
    import hq_pkg::*;

    localparam int     CLK_PERIOD = 4;
    localparam int     NUM_TESTS  = 5;
    localparam int     NUM_ITEMS  = `HQ_NUM_CW * `HQ_NUM_CHUNKS;
    localparam int     START_LAT  = 4;
    localparam int     RAND_LIM   = 8 << `HQ_FRAC_BITS;
    localparam longint HALF_VAL   = longint'(1) << (`HQ_FRAC_BITS - 1);

    logic    clk;
    logic    rst;
    logic    start_i;
    h_mat_t  h_mat;
    cplx_t   hq;
    logic    hq_valid;
    logic    cw_done;
    logic    all_done;
    sample_t exp_re [NUM_ITEMS];
    sample_t exp_im [NUM_ITEMS];
    int      seed;
    int      value_errs;
    int      flag_errs;
    int      timing_errs;

    // Row 2 at j=0, j=1, then row 3 at j=0, j=1
    logic [31:0] cb_pairs [`HQ_NUM_CW] = '{
        "PPNP", "PJJP", "PNPP", "PMMP", "NPNN", "NJJN", "NNPN", "NMMN",
        "JPNJ", "JJJJ", "JNPJ", "JMMJ", "MPNM", "MJJM", "MNPM", "MMMM"
    };

    hq_precoder_top uut (
        .clk        (clk),
        .rst        (rst),
        .start_i    (start_i),
        .h_mat_i    (h_mat),
        .hq_o       (hq),
        .hq_valid_o (hq_valid),
        .cw_done_o  (cw_done),
        .all_done_o (all_done)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [7:0] cb_symbol(int q, int k, int j);
        logic [31:0] pairs;
        pairs = cb_pairs[q];
        case (k)
            0:       return "P";
            1:       return (j == 1) ? "P" : "N";
            2:       return (j == 1) ? pairs[23:16] : pairs[31:24];
            default: return (j == 1) ? pairs[7:0] : pairs[15:8];
        endcase
    endfunction

    // Codeword-major, column-minor
    function automatic void compute_expected();
        longint     sr;
        longint     si;
        longint     ar;
        longint     ai;
        sample_t    acc_re;
        sample_t    acc_im;
        logic [7:0] sym;
        int         c;
        for (int n = 0; n < NUM_ITEMS; n++) begin
            c = n % `HQ_NUM_CHUNKS;
            acc_re = '0;
            acc_im = '0;
            for (int k = 0; k < `HQ_NUM_ROWS; k++) begin
                sym = cb_symbol(n / `HQ_NUM_CHUNKS, k, c % 2);
                sr = 0;
                si = 0;
                case (sym)
                    "P":     sr = HALF_VAL;
                    "N":     sr = -HALF_VAL;
                    "J":     si = HALF_VAL;
                    "M":     si = -HALF_VAL;
                    default: ;
                endcase
                ar = longint'(h_mat[k][c].re);
                ai = longint'(h_mat[k][c].im);
                acc_re = acc_re + sample_t'((ar * sr - ai * si) >>> `HQ_FRAC_BITS);
                acc_im = acc_im + sample_t'((ar * si + ai * sr) >>> `HQ_FRAC_BITS);
            end
            exp_re[n] = acc_re;
            exp_im[n] = acc_im;
        end
    endfunction

    task automatic fill_real_h(input int offset);
        for (int k = 0; k < `HQ_NUM_ROWS; k++) begin
            for (int c = 0; c < `HQ_NUM_CHUNKS; c++) begin
                h_mat[k][c].re = sample_t'(((k * 8 + c + offset) % 7 - 3) << `HQ_FRAC_BITS);
                h_mat[k][c].im = '0;
            end
        end
    endtask

    task automatic fill_random_h();
        for (int k = 0; k < `HQ_NUM_ROWS; k++) begin
            for (int c = 0; c < `HQ_NUM_CHUNKS; c++) begin
                h_mat[k][c].re = sample_t'($random(seed) % RAND_LIM);
                h_mat[k][c].im = sample_t'($random(seed) % RAND_LIM);
            end
        end
    endtask

    // One full run, optionally with a second start pulse in the middle
    task automatic run_frame(input bit start_mid_run);
        int wait_cycles;
        int col;
        wait_cycles = 0;
        @(negedge clk);
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        while (!hq_valid && wait_cycles <= START_LAT + 4) begin
            @(negedge clk);
            wait_cycles++;
        end
        assert (wait_cycles == START_LAT) else begin
            $display("FAILED at %0t: first output after %0d edges, expected %0d",
                     $time, wait_cycles, START_LAT);
            timing_errs++;
        end
        for (int n = 0; n < NUM_ITEMS; n++) begin
            col = n % `HQ_NUM_CHUNKS;
            start_i = start_mid_run && (n == NUM_ITEMS / 3);
            assert (hq.re == exp_re[n] && hq.im == exp_im[n]) else begin
                $display("FAILED at %0t: output %0d got %h %h expected %h %h",
                         $time, n, hq.re, hq.im, exp_re[n], exp_im[n]);
                value_errs++;
            end
            assert ({hq_valid, cw_done, all_done} ==
                    {1'b1, col == `HQ_NUM_CHUNKS - 1, n == NUM_ITEMS - 1}) else begin
                $display("FAILED at %0t: output %0d flags valid/cw/all = %b%b%b",
                         $time, n, hq_valid, cw_done, all_done);
                flag_errs++;
            end
            @(negedge clk);
        end
        start_i = 1'b0;
        assert (!hq_valid) else begin
            $display("FAILED at %0t: hq_valid_o still high after output %0d", $time, NUM_ITEMS);
            flag_errs++;
        end
    endtask

    task automatic check_idle_outputs();
        for (int i = 0; i < 20; i++) begin
            assert (!hq_valid && !cw_done && !all_done) else begin
                $display("FAILED at %0t: output flags %b%b%b while idle",
                         $time, hq_valid, cw_done, all_done);
                flag_errs++;
            end
            @(negedge clk);
        end
    endtask

    initial begin
        #((NUM_TESTS * 140 + 50) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected number of cycles");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        seed        = 40;
        value_errs  = 0;
        flag_errs   = 0;
        timing_errs = 0;
        rst         = 1'b1;
        start_i     = 1'b0;
        h_mat       = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        check_idle_outputs();
        fill_real_h(0);
        compute_expected();
        run_frame(1'b0);
        fill_random_h();
        compute_expected();
        run_frame(1'b0);
        // Same H, start pulse while busy
        run_frame(1'b1);
        fill_real_h(3);
        compute_expected();
        run_frame(1'b0);

        $display("Errors: value %0d, flag %0d, timing %0d", value_errs, flag_errs, timing_errs);
        if (value_errs + flag_errs + timing_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* hq_precoder.f */
+incdir+common
common/hq_pkg.sv
hw/hq_sequencer.sv
hw/codebook_fetch.sv
hw/cmult/cmult_lane.sv
hw/cmult/hq_mult_stage.sv
hw/hq_sum_stage.sv
hw/hq_precoder_top.sv
sim/hq_precoder_properties.sv
sim/hq_precoder_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the precoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module hq_precoder_tb -f hq_precoder.f -o hq_precoder_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/hq_precoder_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
exit 0
